// File: all.f
source/mapperPkg.sv
source/backgroundFetch.sv
source/tankRenderer.sv
source/pixelCompositor.sv
source/colorMapper.sv
test/colorMapper_props.sv
test/colorMapperTb.sv

// File: run.sh
#!/bin/sh
# build the color mapper testbench with Verilator, run it, and judge the printed result
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module colorMapperTb -f all.f \
	&& ./obj_dir/VcolorMapperTb | tee /dev/stderr \
		| grep -q "Simulation completed successfully" \
	&& echo "RESULT: PASS" \
	|| { echo "RESULT: FAIL"; exit 1; }

// File: source/backgroundFetch.sv
// background frame-buffer addressing, nibble select and palette conversion

`timescale 1ns/1ps

module backgroundFetch import mapperPkg::*; (
	input drawPos_t pos,
	input bgByte_u bgData,
	output logic [bgAddrW-1:0] bgAddr,
	output rgb_t bgRgb
);

	// pixel index in the half-resolution image is one bit wider than a byte address
	logic [bgAddrW:0] halfIdx;
	logic [3:0] colorIdx;

	// -------------------------------------------------------------------------
	// address generation
	assign halfIdx = (bgAddrW+1)'(pos.drawY[coordW-1:1] * bgRowWords)
		+ (bgAddrW+1)'(pos.drawX[coordW-1:1]);

	// two pixels share a byte
	assign bgAddr = halfIdx[bgAddrW:1];

	// -------------------------------------------------------------------------
	// nibble select
	always_comb begin
		if (pos.drawX[0] == 1'b0) begin
			colorIdx = bgData.idx.hiIdx;
		end else begin
			colorIdx = bgData.idx.loIdx;
		end
	end

	assign bgRgb = paletteColor(colorIdx);

endmodule

// File: source/colorMapper.sv
// color mapper top level with background fetch, two tank renderers and compositor

`timescale 1ns/1ps

module colorMapper import mapperPkg::*; (
	input logic VGA_Clk,
	input logic Reset,
	input drawPos_t pos,
	input tankIn_t playerA,
	input tankIn_t playerB,
	input gameState_t gameState,
	input bgByte_u bgData,
	input logic [3:0] spriteIdxA,
	input logic [3:0] spriteIdxB,
	output logic [bgAddrW-1:0] bgAddr,
	output logic [spriteAddrW-1:0] spriteAddrA,
	output logic [spriteAddrW-1:0] spriteAddrB,
	output rgb_t pixel
);

	rgb_t bgRgb;
	tankLayer_t layerA;
	tankLayer_t layerB;

	// -------------------------------------------------------------------------
	// background
	backgroundFetch i_background (
		.pos(pos),
		.bgData(bgData),
		.bgAddr(bgAddr),
		.bgRgb(bgRgb)
	);

	// -------------------------------------------------------------------------
	// tanks rendered side by side
	tankRenderer i_tankA (
		.pos(pos),
		.player(playerA),
		.spriteIdx(spriteIdxA),
		.spriteAddr(spriteAddrA),
		.layer(layerA)
	);

	tankRenderer i_tankB (
		.pos(pos),
		.player(playerB),
		.spriteIdx(spriteIdxB),
		.spriteAddr(spriteAddrB),
		.layer(layerB)
	);

	// -------------------------------------------------------------------------
	// final priority and output register
	pixelCompositor i_compositor (
		.VGA_Clk(VGA_Clk),
		.Reset(Reset),
		.drawX(pos.drawX),
		.gameState(gameState),
		.bgRgb(bgRgb),
		.layerA(layerA),
		.layerB(layerB),
		.pixel(pixel)
	);

endmodule

// File: source/mapperPkg.sv
// screen and sprite constants, pixel structs, frame-buffer byte union, palette function

package mapperPkg;

	// -------------------------------------------------------------------------
	// screen geometry
	localparam int screenW = 640;
	localparam int screenH = 480;
	localparam int coordW = 10;

	// half-resolution frame buffer with two pixels per byte
	localparam int bgRowWords = 320;
	localparam int bgAddrW = 16;

	// tank body window and sprite memory layout
	localparam int tankW = 100;
	localparam int tankH = 80;
	localparam int spriteStride = 100;
	localparam int spriteAddrW = 16;

	localparam int bulletRadius = 4;
	localparam logic [23:0] keyColor = 24'hB0B0B0;
	localparam int bulletStep = 16;

	// -------------------------------------------------------------------------
	typedef logic [1:0] gameState_t;

	localparam gameState_t stateSelect = 2'd0;
	localparam gameState_t stateFight = 2'd1;

	typedef struct packed {
		logic [7:0] red;
		logic [7:0] green;
		logic [7:0] blue;
	} rgb_t;

	typedef struct packed {
		logic [coordW-1:0] drawX;
		logic [coordW-1:0] drawY;
	} drawPos_t;

	// one player's inputs that hold steady over a frame
	typedef struct packed {
		logic [coordW-1:0] tankX;
		logic [coordW-1:0] tankY;
		logic [coordW-1:0] bulletX;
		logic [coordW-1:0] bulletY;
		logic [1:0] tankChoice;
	} tankIn_t;

	// what one tank contributes to the current pixel
	typedef struct packed {
		logic inBody;
		logic bodyOpaque;
		logic onBullet;
		rgb_t bodyRgb;
		rgb_t bulletRgb;
	} tankLayer_t;

	// high nibble is the even pixel
	typedef union packed {
		logic [7:0] byteVal;
		struct packed {
			logic [3:0] hiIdx;
			logic [3:0] loIdx;
		} idx;
	} bgByte_u;

	function automatic rgb_t paletteColor(input logic [3:0] colorIdx);
		case (colorIdx)
			4'h0: paletteColor = keyColor;
			4'h1: paletteColor = 24'h000000;
			4'h2: paletteColor = 24'hFFFFFF;
			4'h3: paletteColor = 24'h3B5323;
			4'h4: paletteColor = 24'h556B2F;
			4'h5: paletteColor = 24'h8B4513;
			4'h6: paletteColor = 24'hA0522D;
			4'h7: paletteColor = 24'h2F4F4F;
			4'h8: paletteColor = 24'h708090;
			4'h9: paletteColor = 24'h87CEEB;
			4'hA: paletteColor = 24'h4682B4;
			4'hB: paletteColor = 24'hDAA520;
			4'hC: paletteColor = 24'hB22222;
			4'hD: paletteColor = 24'h228B22;
			4'hE: paletteColor = 24'hF4A460;
			default: paletteColor = 24'h696969;
		endcase
	endfunction

endpackage

// File: source/pixelCompositor.sv
// game-state layer priority and registered output color

`timescale 1ns/1ps

module pixelCompositor import mapperPkg::*; (
	input logic VGA_Clk,
	input logic Reset,
	input logic [coordW-1:0] drawX,
	input gameState_t gameState,
	input rgb_t bgRgb,
	input tankLayer_t layerA,
	input tankLayer_t layerB,
	output rgb_t pixel
);

	rgb_t nextPixel;
	rgb_t fightSky;
	rgb_t overSky;
	logic [7:0] scanShade;

	// -------------------------------------------------------------------------
	// horizontal gradients for the fight and game-over screens
	assign scanShade = 8'(drawX >> 3);

	assign fightSky.red = 8'h7F - scanShade;
	assign fightSky.green = 8'h00;
	assign fightSky.blue = 8'h00;

	assign overSky.red = 8'h00;
	assign overSky.green = 8'hFF - scanShade;
	assign overSky.blue = 8'hFF;

	// -------------------------------------------------------------------------
	// layer selection
	always_comb begin
		case (gameState)
			stateSelect: begin
				// key color shows the background through the body
				if (layerA.inBody) begin
					nextPixel = layerA.bodyOpaque ? layerA.bodyRgb : bgRgb;
				end else if (layerB.inBody) begin
					nextPixel = layerB.bodyOpaque ? layerB.bodyRgb : bgRgb;
				end else begin
					nextPixel = bgRgb;
				end
			end

			stateFight: begin
				// bullets over bodies and B over A
				if (layerB.onBullet) begin
					nextPixel = layerB.bulletRgb;
				end else if (layerA.onBullet) begin
					nextPixel = layerA.bulletRgb;
				end else if (layerB.inBody) begin
					nextPixel = layerB.bodyRgb;
				end else if (layerA.inBody) begin
					nextPixel = layerA.bodyRgb;
				end else begin
					nextPixel = fightSky;
				end
			end

			default: begin
				nextPixel = overSky;
			end
		endcase
	end

	// one pixel per clock
	always_ff @(posedge VGA_Clk or posedge Reset) begin
		if (Reset) begin
			pixel <= '0;
		end else begin
			pixel <= nextPixel;
		end
	end

endmodule

// File: source/tankRenderer.sv
// single tank body window, sprite addressing, transparency and bullet disk

`timescale 1ns/1ps

module tankRenderer import mapperPkg::*; (
	input drawPos_t pos,
	input tankIn_t player,
	input logic [3:0] spriteIdx,
	output logic [spriteAddrW-1:0] spriteAddr,
	output tankLayer_t layer
);

	// signed offsets one bit wider than a coordinate
	logic signed [coordW:0] bodyDx;
	logic signed [coordW:0] bodyDy;
	logic signed [coordW:0] shotDx;
	logic signed [coordW:0] shotDy;

	// offsets clamped into the body window
	logic [coordW-1:0] winX;
	logic [coordW-1:0] winY;

	logic [2*coordW+1:0] shotSqX;
	logic [2*coordW+1:0] shotSqY;
	logic [2*coordW+2:0] shotDist;
	logic [7:0] choiceShade;
	logic [7:0] fadeShade;

	// -------------------------------------------------------------------------
	// body window
	assign bodyDx = signed'({1'b0, pos.drawX}) - signed'({1'b0, player.tankX});
	assign bodyDy = signed'({1'b0, pos.drawY}) - signed'({1'b0, player.tankY});

	assign layer.inBody = (bodyDx >= 0) && (bodyDy >= 0)
		&& (bodyDx <= tankW) && (bodyDy <= tankH);

	always_comb begin
		if (bodyDx < 0) begin
			winX = '0;
		end else if (bodyDx > tankW) begin
			winX = coordW'(tankW);
		end else begin
			winX = bodyDx[coordW-1:0];
		end

		if (bodyDy < 0) begin
			winY = '0;
		end else if (bodyDy > tankH) begin
			winY = coordW'(tankH);
		end else begin
			winY = bodyDy[coordW-1:0];
		end
	end

	// row-major sprite without tilt
	assign spriteAddr = spriteAddrW'(winY * spriteStride) + spriteAddrW'(winX);

	assign layer.bodyRgb = paletteColor(spriteIdx);
	assign layer.bodyOpaque = (layer.bodyRgb != keyColor);

	// -------------------------------------------------------------------------
	// bullet disk
	assign shotDx = signed'({1'b0, pos.drawX}) - signed'({1'b0, player.bulletX});
	assign shotDy = signed'({1'b0, pos.drawY}) - signed'({1'b0, player.bulletY});

	assign shotSqX = shotDx * shotDx;
	assign shotSqY = shotDy * shotDy;
	assign shotDist = (2*coordW+3)'(shotSqX) + (2*coordW+3)'(shotSqY);

	assign layer.onBullet = (shotDist <= bulletRadius * bulletRadius);

	// magenta for choice 0 fading to green for choice 3
	assign choiceShade = 8'(player.tankChoice) * 8'(bulletStep);
	assign fadeShade = 8'((4 - player.tankChoice) * bulletStep);

	assign layer.bulletRgb.red = fadeShade;
	assign layer.bulletRgb.green = choiceShade;
	assign layer.bulletRgb.blue = fadeShade;

endmodule

// File: test/colorMapperTb.sv
// color mapper testbench with clock, reset, vector file reader, driver, checker and watchdog

`timescale 1ns/1ps

module colorMapperTb import mapperPkg::*; ();

	localparam string vectorPath = "test/colorMapperVectors.txt";
	localparam int numCols = 20;

	// one row of the vector file with stimulus followed by expected responses
	typedef struct packed {
		gameState_t gameState;
		drawPos_t pos;
		tankIn_t playerA;
		tankIn_t playerB;
		bgByte_u bgData;
		logic [3:0] spriteIdxA;
		logic [3:0] spriteIdxB;
		logic [bgAddrW-1:0] bgAddr;
		logic [spriteAddrW-1:0] spriteAddrA;
		logic [spriteAddrW-1:0] spriteAddrB;
		rgb_t pixel;
	} vector_t;

	logic VGA_Clk;
	logic Reset;
	drawPos_t pos;
	tankIn_t playerA;
	tankIn_t playerB;
	gameState_t gameState;
	bgByte_u bgData;
	logic [3:0] spriteIdxA;
	logic [3:0] spriteIdxB;
	logic [bgAddrW-1:0] bgAddr;
	logic [spriteAddrW-1:0] spriteAddrA;
	logic [spriteAddrW-1:0] spriteAddrB;
	rgb_t pixel;

	vector_t vectors[$];
	int vectorCount = 0;
	logic vectorsLoaded = 1'b0;

	colorMapper i_dut (
		.VGA_Clk(VGA_Clk),
		.Reset(Reset),
		.pos(pos),
		.playerA(playerA),
		.playerB(playerB),
		.gameState(gameState),
		.bgData(bgData),
		.spriteIdxA(spriteIdxA),
		.spriteIdxB(spriteIdxB),
		.bgAddr(bgAddr),
		.spriteAddrA(spriteAddrA),
		.spriteAddrB(spriteAddrB),
		.pixel(pixel)
	);

	always #5 VGA_Clk = ~VGA_Clk;

	// ---------------------------------------------------------------------------
	// error reporting
	task automatic stopWithFailure(input string why);
		$display("%s", why);
		$display("Simulation failed");
		$fatal(1, "stopping at the first error");
	endtask

	task automatic reportMismatch(input string name, input int index,
		input logic [31:0] expected, input logic [31:0] actual);
		stopWithFailure($sformatf("Mismatch %s at vector %0d: expected 0x%0h, got 0x%0h",
			name, index, expected, actual));
	endtask

	// ---------------------------------------------------------------------------
	// vector file reader
	function automatic bit ignoredLine(input string line);
		if (line.len() < 2) begin
			return 1'b1;
		end
		return (line.substr(0, 1) == "//");
	endfunction

	task automatic loadVectors();
		int fd;
		int got;
		bit haveCount;
		string line;
		logic [31:0] col [numCols];
		vector_t v;

		haveCount = 1'b0;
		fd = $fopen(vectorPath, "r");
		if (fd == 0) begin
			stopWithFailure("the vector file could not be opened");
		end
		while (!$feof(fd)) begin
			line = "";
			got = $fgets(line, fd);
			if (got > 0 && !ignoredLine(line)) begin
				if (!haveCount) begin
					got = $sscanf(line, "%d", vectorCount);
					if (got != 1) begin
						stopWithFailure("the count line of the vector file is unreadable");
					end
					haveCount = 1'b1;
				end else begin
					got = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
						col[0], col[1], col[2], col[3], col[4], col[5], col[6],
						col[7], col[8], col[9], col[10], col[11], col[12], col[13],
						col[14], col[15], col[16], col[17], col[18], col[19]);
					if (got != numCols) begin
						stopWithFailure("a vector line does not hold twenty hex fields");
					end
					v.gameState = col[0][1:0];
					v.pos.drawX = col[1][coordW-1:0];
					v.pos.drawY = col[2][coordW-1:0];
					v.playerA.tankX = col[3][coordW-1:0];
					v.playerA.tankY = col[4][coordW-1:0];
					v.playerA.bulletX = col[5][coordW-1:0];
					v.playerA.bulletY = col[6][coordW-1:0];
					v.playerA.tankChoice = col[7][1:0];
					v.playerB.tankX = col[8][coordW-1:0];
					v.playerB.tankY = col[9][coordW-1:0];
					v.playerB.bulletX = col[10][coordW-1:0];
					v.playerB.bulletY = col[11][coordW-1:0];
					v.playerB.tankChoice = col[12][1:0];
					v.bgData.byteVal = col[13][7:0];
					v.spriteIdxA = col[14][3:0];
					v.spriteIdxB = col[15][3:0];
					v.bgAddr = col[16][bgAddrW-1:0];
					v.spriteAddrA = col[17][spriteAddrW-1:0];
					v.spriteAddrB = col[18][spriteAddrW-1:0];
					v.pixel = col[19][23:0];
					vectors.push_back(v);
				end
			end
		end
		$fclose(fd);
		if (vectorCount == 0 || vectors.size() != vectorCount) begin
			stopWithFailure($sformatf("the vector file holds %0d rows but its count line says %0d",
				vectors.size(), vectorCount));
		end
	endtask

	// ---------------------------------------------------------------------------
	// driver and checkers
	task automatic driveVector(input vector_t v);
		gameState = v.gameState;
		pos = v.pos;
		playerA = v.playerA;
		playerB = v.playerB;
		bgData = v.bgData;
		spriteIdxA = v.spriteIdxA;
		spriteIdxB = v.spriteIdxB;
	endtask

	// addresses are combinational and valid in the cycle of their inputs
	task automatic checkAddresses(input int index);
		vector_t v;

		v = vectors[index];
		assert (bgAddr == v.bgAddr)
			else reportMismatch("bgAddr", index, 32'(v.bgAddr), 32'(bgAddr));
		assert (spriteAddrA == v.spriteAddrA)
			else reportMismatch("spriteAddrA", index, 32'(v.spriteAddrA), 32'(spriteAddrA));
		assert (spriteAddrB == v.spriteAddrB)
			else reportMismatch("spriteAddrB", index, 32'(v.spriteAddrB), 32'(spriteAddrB));
	endtask

	task automatic checkPixel(input int index);
		assert (pixel == vectors[index].pixel)
			else reportMismatch("pixel", index, 32'(vectors[index].pixel), 32'(pixel));
	endtask

	// ---------------------------------------------------------------------------
	initial begin
		VGA_Clk = 1'b0;
		Reset = 1'b1;
		pos = '0;
		playerA = '0;
		playerB = '0;
		gameState = stateSelect;
		bgData = '0;
		spriteIdxA = '0;
		spriteIdxB = '0;
		loadVectors();
		vectorsLoaded = 1'b1;

		repeat (4) @(posedge VGA_Clk);
		@(negedge VGA_Clk);
		Reset = 1'b0;
		#1;
		assert (pixel == '0)
			else stopWithFailure($sformatf("Mismatch pixel after reset: expected 0x0, got 0x%0h",
				pixel));

		// pixel of each vector appears one clock after its inputs
		for (int i = 0; i < vectors.size(); i++) begin
			@(negedge VGA_Clk);
			if (i > 0) begin
				checkPixel(i - 1);
			end
			driveVector(vectors[i]);
			#1;
			checkAddresses(i);
		end
		@(negedge VGA_Clk);
		checkPixel(vectors.size() - 1);

		$display("Simulation completed successfully");
		$finish;
	end

	// watchdog sized from the vector count
	initial begin
		wait (vectorsLoaded);
		#((vectorCount + 20) * 10);
		stopWithFailure("timeout: the vector run did not finish in the expected time");
	end

endmodule

// File: test/colorMapperVectors.txt
// count line, then per row in hex: gameState drawX drawY, A tankX tankY bulletX bulletY choice,
// B tankX tankY bulletX bulletY choice, bgData spriteIdxA spriteIdxB | bgAddr sprA sprB pixel
30
0 00A 014 064 0C8 3FF 3FF 1 190 0C8 3FF 3FF 2 5C 1 1 0642 0000 0000 8B4513
0 00B 014 064 0C8 3FF 3FF 1 190 0C8 3FF 3FF 2 5C 1 1 0642 0000 0000 B22222
0 27E 1DF 064 0C8 3FF 3FF 1 190 0C8 3FF 3FF 2 9A 1 1 95FF 1FA4 1FA4 87CEEB
0 003 001 064 0C8 3FF 3FF 1 190 0C8 3FF 3FF 2 E7 1 1 0000 0000 0000 2F4F4F
0 064 0C8 064 0C8 3FF 3FF 1 190 0C8 3FF 3FF 2 11 3 1 3E99 0000 0000 3B5323
0 0C8 118 064 0C8 3FF 3FF 1 190 0C8 3FF 3FF 2 22 4 1 57B2 1FA4 1F40 556B2F
0 096 0F0 064 0C8 3FF 3FF 1 190 0C8 3FF 3FF 2 D3 0 1 4B25 0FD2 0FA0 228B22
0 0C9 0F0 064 0C8 3FF 3FF 1 190 0C8 3FF 3FF 2 D3 5 1 4B32 1004 0FA0 3B5323
0 1C2 0D2 064 0C8 3FF 3FF 1 190 0C8 3FF 3FF 2 11 2 B 4210 044C 041A DAA520
0 1C4 0D2 064 0C8 3FF 3FF 1 190 0C8 3FF 3FF 2 81 2 0 4211 044C 041C 708090
0 0B4 0FA 064 0C8 3FF 3FF 1 096 0DC 3FF 3FF 2 22 6 C 4E4D 13D8 0BD6 A0522D
0 0B4 0FA 064 0C8 3FF 3FF 1 096 0DC 3FF 3FF 2 2F 0 C 4E4D 13D8 0BD6 FFFFFF
0 190 0C8 064 0C8 3FF 3FF 1 190 0C8 3FF 3FF 2 11 3 E 3EE4 0064 0000 F4A460
0 063 0C7 064 0C8 3FF 3FF 1 190 0C8 3FF 3FF 2 97 3 1 3DF8 0000 0000 2F4F4F
1 12E 065 064 0C8 12C 064 1 190 0C8 12C 064 2 11 1 1 1F8B 0064 0000 202020
1 12C 068 064 0C8 3FF 3FF 1 190 0C8 12C 064 2 11 1 1 20CB 0064 0000 202020
1 12F 066 064 0C8 12C 064 1 190 0C8 3FF 3FF 2 11 1 1 202B 0064 0000 301030
1 12F 067 064 0C8 12C 064 1 190 0C8 3FF 3FF 2 11 1 1 202B 0064 0000 5A0000
1 096 0F0 064 0C8 096 0F0 1 190 0C8 3FF 3FF 2 11 3 1 4B25 0FD2 0FA0 301030
1 1C2 0D2 064 0C8 3FF 3FF 1 190 0C8 3FF 3FF 2 11 2 0 4210 044C 041A B0B0B0
1 096 0F0 064 0C8 3FF 3FF 1 190 0C8 3FF 3FF 2 11 9 1 4B25 0FD2 0FA0 87CEEB
1 0B4 0FA 064 0C8 3FF 3FF 1 096 0DC 3FF 3FF 2 11 6 C 4E4D 13D8 0BD6 B22222
1 00A 014 064 0C8 3FF 3FF 1 190 0C8 3FF 3FF 2 11 1 1 0642 0000 0000 7E0000
1 27E 1DF 064 0C8 3FF 3FF 1 190 0C8 3FF 3FF 2 11 1 1 95FF 1FA4 1FA4 300000
1 1F4 12C 064 0C8 3FF 3FF 1 190 0C8 1F4 12C 3 11 1 1 5E3D 1FA4 1FA4 103010
1 016 020 064 0C8 014 01E 0 190 0C8 3FF 3FF 2 11 1 1 0A05 0000 0000 400040
2 096 0F0 064 0C8 096 0F0 1 190 0C8 3FF 3FF 2 11 3 1 4B25 0FD2 0FA0 00EDFF
3 12E 065 064 0C8 12C 064 1 190 0C8 12C 064 2 11 1 1 1F8B 0064 0000 00DAFF
2 000 000 064 0C8 3FF 3FF 1 190 0C8 3FF 3FF 2 11 1 1 0000 0000 0000 00FFFF
0 27F 1DE 064 0C8 3FF 3FF 1 190 0C8 3FF 3FF 2 4E 1 1 95FF 1FA4 1FA4 F4A460

// File: test/colorMapper_props.sv
// concurrent checks on the color mapper top level, attached with bind

`timescale 1ns/1ps

module colorMapperProps import mapperPkg::*; (
	input logic VGA_Clk,
	input logic Reset,
	input gameState_t gameState,
	input logic [bgAddrW-1:0] bgAddr,
	input rgb_t pixel
);

	// output register held clear
	resetClear: assert property (@(posedge VGA_Clk) Reset |-> (pixel == '0))
		else $error("pixel is not zero while Reset is high");

	// game-over screen is always full blue
	overBlue: assert property (@(posedge VGA_Clk) disable iff (Reset)
		(gameState != stateSelect && gameState != stateFight) |=> (pixel.blue == 8'hFF))
		else $error("blue is not FF one cycle after a game-over state");

	// half-resolution buffer holds two pixels per byte
	addrRange: assert property (@(posedge VGA_Clk) disable iff (Reset)
		(int'(bgAddr) < screenW * screenH / 8))
		else $error("bgAddr points past the end of the frame buffer");

endmodule

bind colorMapper colorMapperProps i_props (
	.VGA_Clk(VGA_Clk),
	.Reset(Reset),
	.gameState(gameState),
	.bgAddr(bgAddr),
	.pixel(pixel)
);
